// File: Makefile
SIM_DIR = obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module dcache_tb

sim:
	verilator --binary --timing --assert -f compile.f --top-module dcache_tb \
		--Mdir $(SIM_DIR) -o dcache_sim
	out="$$(./$(SIM_DIR)/dcache_sim)"; echo "$$out"; \
		echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf $(SIM_DIR)

// File: compile.f
+incdir+logic
logic/dcache_pkg.sv
logic/dcache_ways.sv
logic/dcache_pipeline.sv
logic/dcache_miss_ctrl.sv
logic/dcache_top.sv
sim/dcache_chk.sv
sim/dcache_tb.sv

// File: logic/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// cpu address width
`define DCACHE_ADDR_W 32

// one cache line, four 32-bit words
`define DCACHE_LINE_W 128

// geometry
`define DCACHE_NSET 64
`define DCACHE_NWAY 2

// address split: tag | index | offset
`define DCACHE_OFFSET_W 4
`define DCACHE_INDEX_W 6
`define DCACHE_TAG_W 22

// victim selection
`define DCACHE_LFSR_W 16

`endif

// File: logic/dcache_miss_ctrl.sv
`default_nettype none

`include "dcache_config.svh"

module dcache_miss_ctrl (
    input  wire                                         clk,
    input  wire                                         rst,
    input  wire                                         miss_i,
    input  dcache_pkg::addr_u                           miss_addr_i,
    input  wire  [3:0]                                  miss_wstrb_i,
    input  wire  [31:0]                                 miss_wdata_i,
    input  dcache_pkg::tag_entry_t [`DCACHE_NWAY-1:0]   miss_tags_i,
    input  wire  [`DCACHE_NWAY-1:0][`DCACHE_LINE_W-1:0] miss_lines_i,
    output logic                                        busy_o,
    output logic [`DCACHE_NWAY-1:0]                     refill_en_o,
    output dcache_pkg::tag_entry_t                      refill_tag_o,
    output logic [`DCACHE_LINE_W-1:0]                   refill_line_o,
    output logic                                        refill_done_o,
    output logic [31:0]                                 refill_word_o,
    output logic                                        mem_req_o,
    output logic                                        mem_we_o,
    output logic [`DCACHE_ADDR_W-1:0]                   mem_addr_o,
    output logic [`DCACHE_LINE_W-1:0]                   mem_wdata_o,
    input  wire                                         mem_rdy_i,
    input  wire                                         mem_rvalid_i,
    input  wire  [`DCACHE_LINE_W-1:0]                   mem_rdata_i,
    input  wire                                         mem_bvalid_i
);

    dcache_pkg::miss_state_e state_q, state_d;
    logic [`DCACHE_LFSR_W-1:0] lfsr_q;
    logic victim_q, victim_d;
    dcache_pkg::addr_u wb_addr;
    logic [`DCACHE_LINE_W/8-1:0] store_be;
    logic [`DCACHE_LINE_W-1:0] merged;

    // empty ways are filled before anything is evicted
    always_comb begin
        if (!miss_tags_i[0].valid) begin
            victim_d = 1'b0;
        end else if (!miss_tags_i[1].valid) begin
            victim_d = 1'b1;
        end else begin
            victim_d = lfsr_q[0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= dcache_pkg::IDLE;
            victim_q <= 1'b0;
            lfsr_q   <= `DCACHE_LFSR_W'hace1;
        end else begin
            state_q <= state_d;
            // taps 16, 14, 13, 11
            lfsr_q  <= {lfsr_q[`DCACHE_LFSR_W-2:0],
                        lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
            if (state_q == dcache_pkg::IDLE && miss_i) begin
                victim_q <= victim_d;
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_pkg::IDLE: begin
                if (miss_i) begin
                    if (miss_tags_i[victim_d].dirty && miss_tags_i[victim_d].valid) begin
                        state_d = dcache_pkg::WB_REQ;
                    end else begin
                        state_d = dcache_pkg::RD_REQ;
                    end
                end
            end
            dcache_pkg::WB_REQ: begin
                if (mem_rdy_i) state_d = dcache_pkg::WB_WAIT;
            end
            dcache_pkg::WB_WAIT: begin
                if (mem_bvalid_i) state_d = dcache_pkg::RD_REQ;
            end
            dcache_pkg::RD_REQ: begin
                if (mem_rdy_i) state_d = dcache_pkg::RD_WAIT;
            end
            dcache_pkg::RD_WAIT: begin
                if (mem_rvalid_i) state_d = dcache_pkg::IDLE;
            end
            default: begin
                state_d = dcache_pkg::IDLE;
            end
        endcase
    end

    assign busy_o = state_q != dcache_pkg::IDLE;

    // victim line address: its own tag on the missing set
    always_comb begin
        wb_addr.f.tag      = miss_tags_i[victim_q].tag;
        wb_addr.f.index    = miss_addr_i.f.index;
        wb_addr.f.word     = 2'b00;
        wb_addr.f.byte_off = 2'b00;
    end

    assign mem_req_o   = state_q == dcache_pkg::WB_REQ || state_q == dcache_pkg::RD_REQ;
    assign mem_we_o    = state_q == dcache_pkg::WB_REQ;
    assign mem_wdata_o = miss_lines_i[victim_q];
    assign mem_addr_o  = mem_we_o ? wb_addr.raw :
                         {miss_addr_i.raw[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W],
                          {`DCACHE_OFFSET_W{1'b0}}};

    // store data from a store miss goes over the returned line
    assign store_be = (`DCACHE_LINE_W/8)'(miss_wstrb_i) << {miss_addr_i.f.word, 2'b00};

    always_comb begin
        for (int b = 0; b < `DCACHE_LINE_W / 8; b++) begin
            if (store_be[b]) begin
                merged[b*8+:8] = miss_wdata_i[(b%4)*8+:8];
            end else begin
                merged[b*8+:8] = mem_rdata_i[b*8+:8];
            end
        end
    end

    assign refill_done_o = state_q == dcache_pkg::RD_WAIT && mem_rvalid_i;
    assign refill_en_o   = refill_done_o ? (`DCACHE_NWAY'(1) << victim_q) : '0;
    assign refill_tag_o  = {miss_wstrb_i != 4'b0, 1'b1, miss_addr_i.f.tag};
    assign refill_line_o = merged;
    assign refill_word_o = merged[miss_addr_i.f.word*32+:32];

endmodule

`default_nettype wire

// File: logic/dcache_pipeline.sv
`default_nettype none

`include "dcache_config.svh"

module dcache_pipeline (
    input  wire                                         clk,
    input  wire                                         rst,
    input  wire                                         req_valid_i,
    input  wire  [`DCACHE_ADDR_W-1:0]                   req_addr_i,
    input  wire  [3:0]                                  req_wstrb_i,
    input  wire  [31:0]                                 req_wdata_i,
    output logic                                        ready_o,
    output logic                                        data_ok_o,
    output logic [31:0]                                 rdata_o,
    output logic                                        rd_en_o,
    output logic [`DCACHE_INDEX_W-1:0]                  rd_set_o,
    input  dcache_pkg::tag_entry_t [`DCACHE_NWAY-1:0]   rd_tags_i,
    input  wire  [`DCACHE_NWAY-1:0][`DCACHE_LINE_W-1:0] rd_lines_i,
    output logic [`DCACHE_NWAY-1:0]                     wr_en_o,
    output logic [`DCACHE_INDEX_W-1:0]                  wr_set_o,
    output dcache_pkg::tag_entry_t                      wr_tag_o,
    output logic [`DCACHE_LINE_W/8-1:0]                 wr_be_o,
    output logic [`DCACHE_LINE_W-1:0]                   wr_line_o,
    input  wire                                         init_done_i,
    output logic                                        miss_o,
    output dcache_pkg::addr_u                           miss_addr_o,
    output logic [3:0]                                  miss_wstrb_o,
    output logic [31:0]                                 miss_wdata_o,
    output dcache_pkg::tag_entry_t [`DCACHE_NWAY-1:0]   miss_tags_o,
    output logic [`DCACHE_NWAY-1:0][`DCACHE_LINE_W-1:0] miss_lines_o,
    input  wire                                         busy_i,
    input  wire  [`DCACHE_NWAY-1:0]                     refill_en_i,
    input  dcache_pkg::tag_entry_t                      refill_tag_i,
    input  wire  [`DCACHE_LINE_W-1:0]                   refill_line_i,
    input  wire                                         refill_done_i,
    input  wire  [31:0]                                 refill_word_i
);

    dcache_pkg::addr_u req_addr, s2_addr, s3_addr;
    logic s2_valid, s3_valid;
    logic [3:0] s2_wstrb, s3_wstrb;
    logic [31:0] s2_wdata, s3_wdata;
    dcache_pkg::tag_entry_t [`DCACHE_NWAY-1:0] s3_tags;
    logic [`DCACHE_NWAY-1:0][`DCACHE_LINE_W-1:0] s3_lines;
    logic [`DCACHE_NWAY-1:0] way_hit;
    logic [`DCACHE_LINE_W-1:0] hit_line;
    logic s3_hit, s3_miss, hold, accept;

    assign req_addr.raw = req_addr_i;

    // stage 3 tag compare
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < `DCACHE_NWAY; w++) begin
            way_hit[w] = s3_tags[w].valid && s3_tags[w].tag == s3_addr.f.tag;
            if (way_hit[w]) begin
                hit_line = s3_lines[w];
            end
        end
    end

    assign s3_hit  = s3_valid && way_hit != '0;
    assign s3_miss = s3_valid && way_hit == '0;
    assign hold    = s3_miss || busy_i;

    // a store in stage 2 leaves a bubble so the next load sees its write
    assign ready_o = init_done_i && !hold && !(s2_valid && s2_wstrb != 4'b0);
    assign accept  = req_valid_i && ready_o;

    // on a stall keep re-reading the stage 2 set so it picks up the refill
    assign rd_en_o  = accept || hold;
    assign rd_set_o = hold ? s2_addr.f.index : req_addr.f.index;

    always_ff @(posedge clk) begin
        if (rst) begin
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else if (refill_done_i) begin
            s3_valid <= 1'b0;
        end else if (!hold) begin
            s2_valid <= accept;
            s3_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            s2_addr  <= req_addr;
            s2_wstrb <= req_wstrb_i;
            s2_wdata <= req_wdata_i;
            s3_addr  <= s2_addr;
            s3_wstrb <= s2_wstrb;
            s3_wdata <= s2_wdata;
            s3_tags  <= rd_tags_i;
            s3_lines <= rd_lines_i;
        end
    end

    // refill from the miss controller wins the write port
    always_comb begin
        wr_set_o = s3_addr.f.index;
        if (refill_en_i != '0) begin
            wr_en_o   = refill_en_i;
            wr_tag_o  = refill_tag_i;
            wr_be_o   = '1;
            wr_line_o = refill_line_i;
        end else begin
            wr_en_o   = way_hit & {`DCACHE_NWAY{s3_hit && s3_wstrb != 4'b0}};
            wr_tag_o  = {1'b1, 1'b1, s3_addr.f.tag};
            wr_be_o   = (`DCACHE_LINE_W/8)'(s3_wstrb) << {s3_addr.f.word, 2'b00};
            wr_line_o = {(`DCACHE_LINE_W/32){s3_wdata}};
        end
    end

    assign data_ok_o = s3_hit || refill_done_i;
    assign rdata_o   = refill_done_i ? refill_word_i : hit_line[s3_addr.f.word*32+:32];

    // busy rises the cycle after the strobe, so this fires once per miss
    assign miss_o       = s3_miss && !busy_i;
    assign miss_addr_o  = s3_addr;
    assign miss_wstrb_o = s3_wstrb;
    assign miss_wdata_o = s3_wdata;
    assign miss_tags_o  = s3_tags;
    assign miss_lines_o = s3_lines;

endmodule

`default_nettype wire

// File: logic/dcache_pkg.sv
`default_nettype none

`include "dcache_config.svh"

package dcache_pkg;

    // address split into tag, set, word in line and byte in word
    typedef struct packed {
        logic [`DCACHE_TAG_W-1:0]   tag;
        logic [`DCACHE_INDEX_W-1:0] index;
        logic [1:0]                 word;
        logic [1:0]                 byte_off;
    } addr_fields_t;

    // one address word, seen raw or split
    typedef union packed {
        logic [`DCACHE_ADDR_W-1:0] raw;
        addr_fields_t              f;
    } addr_u;

    // tag array entry
    typedef struct packed {
        logic                     dirty;
        logic                     valid;
        logic [`DCACHE_TAG_W-1:0] tag;
    } tag_entry_t;

    typedef enum logic [2:0] {
        IDLE,
        WB_REQ,
        WB_WAIT,
        RD_REQ,
        RD_WAIT
    } miss_state_e;

endpackage

`default_nettype wire

// File: logic/dcache_top.sv
`default_nettype none

`include "dcache_config.svh"

module dcache_top (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        req_valid_i,
    input  wire  [`DCACHE_ADDR_W-1:0]  req_addr_i,
    input  wire  [3:0]                 req_wstrb_i,
    input  wire  [31:0]                req_wdata_i,
    output logic                       ready_o,
    output logic                       data_ok_o,
    output logic [31:0]                rdata_o,
    output logic                       mem_req_o,
    output logic                       mem_we_o,
    output logic [`DCACHE_ADDR_W-1:0]  mem_addr_o,
    output logic [`DCACHE_LINE_W-1:0]  mem_wdata_o,
    input  wire                        mem_rdy_i,
    input  wire                        mem_rvalid_i,
    input  wire  [`DCACHE_LINE_W-1:0]  mem_rdata_i,
    input  wire                        mem_bvalid_i
);

    // array ports
    logic rd_en, init_done;
    logic [`DCACHE_INDEX_W-1:0] rd_set, wr_set;
    dcache_pkg::tag_entry_t [`DCACHE_NWAY-1:0] rd_tags;
    logic [`DCACHE_NWAY-1:0][`DCACHE_LINE_W-1:0] rd_lines;
    logic [`DCACHE_NWAY-1:0] wr_en;
    dcache_pkg::tag_entry_t wr_tag;
    logic [`DCACHE_LINE_W/8-1:0] wr_be;
    logic [`DCACHE_LINE_W-1:0] wr_line;

    // pipeline to miss controller
    logic miss, busy, refill_done;
    dcache_pkg::addr_u miss_addr;
    logic [3:0] miss_wstrb;
    logic [31:0] miss_wdata, refill_word;
    dcache_pkg::tag_entry_t [`DCACHE_NWAY-1:0] miss_tags;
    logic [`DCACHE_NWAY-1:0][`DCACHE_LINE_W-1:0] miss_lines;
    logic [`DCACHE_NWAY-1:0] refill_en;
    dcache_pkg::tag_entry_t refill_tag;
    logic [`DCACHE_LINE_W-1:0] refill_line;

    dcache_pipeline pipeline_i (
        .clk(clk), .rst(rst),
        .req_valid_i(req_valid_i), .req_addr_i(req_addr_i),
        .req_wstrb_i(req_wstrb_i), .req_wdata_i(req_wdata_i),
        .ready_o(ready_o), .data_ok_o(data_ok_o), .rdata_o(rdata_o),
        .rd_en_o(rd_en), .rd_set_o(rd_set), .rd_tags_i(rd_tags), .rd_lines_i(rd_lines),
        .wr_en_o(wr_en), .wr_set_o(wr_set), .wr_tag_o(wr_tag),
        .wr_be_o(wr_be), .wr_line_o(wr_line),
        .init_done_i(init_done),
        .miss_o(miss), .miss_addr_o(miss_addr), .miss_wstrb_o(miss_wstrb),
        .miss_wdata_o(miss_wdata), .miss_tags_o(miss_tags), .miss_lines_o(miss_lines),
        .busy_i(busy), .refill_en_i(refill_en), .refill_tag_i(refill_tag),
        .refill_line_i(refill_line), .refill_done_i(refill_done),
        .refill_word_i(refill_word)
    );

    dcache_ways ways_i (
        .clk(clk), .rst(rst),
        .rd_en_i(rd_en), .rd_set_i(rd_set),
        .wr_en_i(wr_en), .wr_set_i(wr_set), .wr_tag_i(wr_tag),
        .wr_be_i(wr_be), .wr_line_i(wr_line),
        .rd_tags_o(rd_tags), .rd_lines_o(rd_lines),
        .init_done_o(init_done)
    );

    dcache_miss_ctrl miss_ctrl_i (
        .clk(clk), .rst(rst),
        .miss_i(miss), .miss_addr_i(miss_addr), .miss_wstrb_i(miss_wstrb),
        .miss_wdata_i(miss_wdata), .miss_tags_i(miss_tags), .miss_lines_i(miss_lines),
        .busy_o(busy), .refill_en_o(refill_en), .refill_tag_o(refill_tag),
        .refill_line_o(refill_line), .refill_done_o(refill_done),
        .refill_word_o(refill_word),
        .mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
        .mem_wdata_o(mem_wdata_o), .mem_rdy_i(mem_rdy_i), .mem_rvalid_i(mem_rvalid_i),
        .mem_rdata_i(mem_rdata_i), .mem_bvalid_i(mem_bvalid_i)
    );

endmodule

`default_nettype wire

// File: logic/dcache_ways.sv
`default_nettype none

`include "dcache_config.svh"

module dcache_ways (
    input  wire                                         clk,
    input  wire                                         rst,
    input  wire                                         rd_en_i,
    input  wire  [`DCACHE_INDEX_W-1:0]                  rd_set_i,
    input  wire  [`DCACHE_NWAY-1:0]                     wr_en_i,
    input  wire  [`DCACHE_INDEX_W-1:0]                  wr_set_i,
    input  dcache_pkg::tag_entry_t                      wr_tag_i,
    input  wire  [`DCACHE_LINE_W/8-1:0]                 wr_be_i,
    input  wire  [`DCACHE_LINE_W-1:0]                   wr_line_i,
    output dcache_pkg::tag_entry_t [`DCACHE_NWAY-1:0]   rd_tags_o,
    output logic [`DCACHE_NWAY-1:0][`DCACHE_LINE_W-1:0] rd_lines_o,
    output logic                                        init_done_o
);

    dcache_pkg::tag_entry_t tag_mem [`DCACHE_NWAY][`DCACHE_NSET];
    logic [`DCACHE_LINE_W-1:0] data_mem [`DCACHE_NWAY][`DCACHE_NSET];
    logic [`DCACHE_INDEX_W-1:0] walk_set;

    // after reset, step through every set once to clear the valid bits
    always_ff @(posedge clk) begin
        if (rst) begin
            walk_set    <= '0;
            init_done_o <= 1'b0;
        end else if (!init_done_o) begin
            walk_set <= walk_set + 1'b1;
            if (walk_set == `DCACHE_INDEX_W'(`DCACHE_NSET - 1)) begin
                init_done_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < `DCACHE_NWAY; w++) begin
            if (!init_done_o) begin
                tag_mem[w][walk_set] <= '0;
            end else if (wr_en_i[w]) begin
                tag_mem[w][wr_set_i] <= wr_tag_i;
            end
            for (int b = 0; b < `DCACHE_LINE_W / 8; b++) begin
                if (wr_en_i[w] && wr_be_i[b]) begin
                    data_mem[w][wr_set_i][b*8+:8] <= wr_line_i[b*8+:8];
                end
            end
            // write-first: a same-set write shows up in the read data
            if (rd_en_i) begin
                if (wr_en_i[w] && wr_set_i == rd_set_i) begin
                    rd_tags_o[w] <= wr_tag_i;
                end else begin
                    rd_tags_o[w] <= tag_mem[w][rd_set_i];
                end
                for (int b = 0; b < `DCACHE_LINE_W / 8; b++) begin
                    if (wr_en_i[w] && wr_be_i[b] && wr_set_i == rd_set_i) begin
                        rd_lines_o[w][b*8+:8] <= wr_line_i[b*8+:8];
                    end else begin
                        rd_lines_o[w][b*8+:8] <= data_mem[w][rd_set_i][b*8+:8];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/dcache_chk.sv
`default_nettype none

`include "dcache_config.svh"

module dcache_chk (
    input wire                       clk,
    input wire                       rst,
    input wire                       data_ok_o,
    input wire                       mem_req_o,
    input wire                       mem_we_o,
    input wire [`DCACHE_ADDR_W-1:0]  mem_addr_o,
    input wire [`DCACHE_LINE_W-1:0]  mem_wdata_o,
    input wire                       mem_rdy_i,
    input wire                       mem_rvalid_i,
    input wire                       mem_bvalid_i
);

    logic outstanding;

    // one memory transfer between its accept and its response
    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 1'b0;
        end else if (mem_req_o && mem_rdy_i) begin
            outstanding <= 1'b1;
        end else if (mem_rvalid_i || mem_bvalid_i) begin
            outstanding <= 1'b0;
        end
    end

    req_held: assert property (@(posedge clk) disable iff (rst)
        mem_req_o && !mem_rdy_i |=> mem_req_o && $stable(mem_we_o)
            && $stable(mem_addr_o) && $stable(mem_wdata_o))
        else $error("memory request changed before mem_rdy_i");

    addr_aligned: assert property (@(posedge clk) disable iff (rst)
        mem_req_o |-> mem_addr_o[`DCACHE_OFFSET_W-1:0] == '0)
        else $error("mem_addr_o is not line aligned");

    no_ok_in_reset: assert property (@(posedge clk) rst |-> !data_ok_o)
        else $error("data_ok_o high during reset");

    one_outstanding: assert property (@(posedge clk) disable iff (rst)
        outstanding |-> !mem_req_o)
        else $error("new memory request while a response is pending");

endmodule

bind dcache_top dcache_chk chk_i (
    .clk(clk), .rst(rst), .data_ok_o(data_ok_o),
    .mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
    .mem_wdata_o(mem_wdata_o), .mem_rdy_i(mem_rdy_i),
    .mem_rvalid_i(mem_rvalid_i), .mem_bvalid_i(mem_bvalid_i)
);

`default_nettype wire

// File: sim/dcache_tb.sv
`default_nettype none

`include "dcache_config.svh"

module dcache_tb;

    localparam int TIMEOUT = 500;

    logic clk, rst, req_valid_i, mem_rdy_i, mem_rvalid_i, mem_bvalid_i;
    logic [31:0] req_addr_i, req_wdata_i, rdata_o;
    logic [3:0] req_wstrb_i;
    logic ready_o, data_ok_o, mem_req_o, mem_we_o;
    logic [31:0] mem_addr_o;
    logic [127:0] mem_wdata_o, mem_rdata_i;

    int seed, errors, cyc, mem_reads, mem_writes;
    logic [127:0] mem_lines [logic [27:0]];
    logic [31:0] shadow [logic [29:0]];
    // requests in flight, oldest first
    logic [31:0] q_addr[$], q_data[$];
    logic [3:0] q_strb[$];
    int q_acc[$];
    bit q_lat[$];

    dcache_top dcache_top_i (.*);

    always #20 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // untouched memory holds a pattern built from the word address
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        fill_word = {a[15:2], 2'b00, a[31:16]} ^ 32'h3c5a96e1;
    endfunction

    function automatic logic [127:0] line_read(input logic [31:0] a);
        logic [127:0] l;
        if (mem_lines.exists(a[31:4])) return mem_lines[a[31:4]];
        for (int i = 0; i < 4; i++) l[i*32+:32] = fill_word({a[31:4], 4'h0} + 32'(i * 4));
        return l;
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] a);
        if (shadow.exists(a[31:2])) return shadow[a[31:2]];
        return fill_word({a[31:2], 2'b00});
    endfunction

    task automatic abort(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $finish;
    endtask

    // memory model, driven on the falling edge
    always @(negedge clk) begin : mem_model
        static bit busy = 0, seen = 0;
        static int wait_cnt = 0, resp_cnt = 0;
        static logic we;
        static logic [31:0] addr;
        logic [127:0] exp_line;
        mem_rdy_i = 1'b0;
        mem_rvalid_i = 1'b0;
        mem_bvalid_i = 1'b0;
        if (busy) begin
            resp_cnt--;
            if (resp_cnt == 0) begin
                busy = 0;
                if (we) mem_bvalid_i = 1'b1;
                else begin
                    mem_rvalid_i = 1'b1;
                    mem_rdata_i = line_read(addr);
                end
            end
        end else if (mem_req_o && !rst) begin
            if (!seen) begin
                seen = 1;
                wait_cnt = $unsigned($random(seed)) % 4;
            end
            if (wait_cnt == 0) begin
                mem_rdy_i = 1'b1;
                seen = 0;
                busy = 1;
                resp_cnt = 1 + $unsigned($random(seed)) % 4;
                we = mem_we_o;
                addr = mem_addr_o;
                if (we) begin
                    mem_writes++;
                    for (int i = 0; i < 4; i++) exp_line[i*32+:32] = shadow_word(addr + 32'(i * 4));
                    if (mem_wdata_o != exp_line) begin
                        errors++;
                        $display("Error at time %0t: mem_wdata_o = %h, expected %h",
                                 $time, mem_wdata_o, exp_line);
                    end
                    mem_lines[addr[31:4]] = mem_wdata_o;
                end else begin
                    mem_reads++;
                end
            end else begin
                wait_cnt--;
            end
        end
    end

    // responses are sampled mid-way between falling and rising edge
    always begin : resp_monitor
        logic [31:0] a, d, exp;
        logic [3:0] s;
        @(negedge clk);
        #10;
        if (data_ok_o) begin
            if (q_addr.size() == 0) begin
                errors++;
                $display("data_ok_o came with no request outstanding at time %0t", $time);
            end else begin
                a = q_addr.pop_front();
                d = q_data.pop_front();
                s = q_strb.pop_front();
                // data_ok_o is taken by the CPU at the next rising edge
                if (q_lat.pop_front() && cyc + 1 - q_acc[0] != 2) begin
                    errors++;
                    $display("Error at time %0t: data_ok_o latency = %0d, expected 2",
                             $time, cyc + 1 - q_acc[0]);
                end
                void'(q_acc.pop_front());
                exp = shadow_word(a);
                if (s == 4'b0) begin
                    if (rdata_o != exp) begin
                        errors++;
                        $display("Error at time %0t: rdata_o = %h, expected %h",
                                 $time, rdata_o, exp);
                    end
                end else begin
                    for (int b = 0; b < 4; b++) if (s[b]) exp[b*8+:8] = d[b*8+:8];
                    shadow[a[31:2]] = exp;
                end
            end
        end
    end

    // drive one request from a falling edge and return after it is accepted
    task automatic issue(input logic [31:0] addr, input logic [3:0] strb,
                         input logic [31:0] data, input bit lat);
        int n;
        n = 0;
        req_valid_i = 1'b1;
        req_addr_i = addr;
        req_wstrb_i = strb;
        req_wdata_i = data;
        while (!ready_o) begin
            if (n == TIMEOUT) abort("ready_o stayed low while a request waited");
            @(negedge clk);
            n++;
        end
        @(negedge clk);
        q_addr.push_back(addr);
        q_data.push_back(data);
        q_strb.push_back(strb);
        q_acc.push_back(cyc);
        q_lat.push_back(lat);
        req_valid_i = 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (q_addr.size() != 0) begin
            if (n == TIMEOUT) abort("a request never got its data_ok_o");
            @(negedge clk);
            n++;
        end
        @(negedge clk);
    endtask

    task automatic load_miss_then_hits();
        int reads;
        issue(32'h0001_2340, 4'b0, 32'h0, 1'b0);
        drain();
        reads = mem_reads;
        for (int i = 1; i < 4; i++) issue(32'h0001_2340 + 32'(i * 4), 4'b0, 32'h0, 1'b1);
        drain();
        if (mem_reads != reads) begin
            errors++;
            $display("Error at time %0t: mem_reads = %0d, expected %0d", $time, mem_reads, reads);
        end
    endtask

    task automatic store_hit_merge();
        issue(32'h0001_2341, 4'b0010, 32'h0000_a500, 1'b0);
        issue(32'h0001_2340, 4'b0, 32'h0, 1'b0);
        issue(32'h0001_2346, 4'b1100, 32'hbeef_0000, 1'b0);
        issue(32'h0001_2344, 4'b0, 32'h0, 1'b0);
        issue(32'h0001_2348, 4'b1111, 32'h1234_5678, 1'b0);
        issue(32'h0001_2348, 4'b0, 32'h0, 1'b0);
        drain();
    endtask

    task automatic dirty_eviction();
        int writes;
        writes = mem_writes;
        for (int t = 1; t <= 3; t++) issue((32'(t + 32) << 10) | 32'h50, 4'b1111, 32'(t * 7), 1'b0);
        for (int t = 1; t <= 3; t++) issue((32'(t + 32) << 10) | 32'h50, 4'b0, 32'h0, 1'b0);
        drain();
        if (mem_writes == writes) begin
            errors++;
            $display("no line write-back was seen for the evicted dirty line");
        end
    endtask

    task automatic store_miss();
        issue(32'h0010_0096, 4'b1100, 32'hcafe_0000, 1'b0);
        issue(32'h0010_0094, 4'b0, 32'h0, 1'b0);
        issue(32'h0010_0090, 4'b0, 32'h0, 1'b0);
        drain();
    endtask

    task automatic random_mix();
        logic [3:0] pats [7] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111};
        logic [3:0] strb;
        logic [31:0] addr;
        int p;
        for (int i = 0; i < 200; i++) begin
            addr = ((32'h100 + $unsigned($random(seed)) % 8) << 10)
                 | ((3 + $unsigned($random(seed)) % 4) << 4)
                 | (($unsigned($random(seed)) % 4) << 2);
            strb = 4'b0;
            if ($random(seed) & 1) begin
                p = $unsigned($random(seed)) % 7;
                strb = pats[p];
                addr[1] = strb[3:2] != 2'b00 && strb[1:0] == 2'b00;
                addr[0] = strb[1] && !strb[0] || strb == 4'b1000;
            end
            issue(addr, strb, $random(seed), 1'b0);
            if ($random(seed) % 4 == 0) @(negedge clk);
        end
        drain();
    endtask

    initial begin
        int n;
        seed = 39;
        errors = 0;
        cyc = 0;
        mem_reads = 0;
        mem_writes = 0;
        clk = 1'b0;
        rst = 1'b1;
        req_valid_i = 1'b0;
        req_addr_i = '0;
        req_wstrb_i = '0;
        req_wdata_i = '0;
        mem_rdy_i = 1'b0;
        mem_rvalid_i = 1'b0;
        mem_bvalid_i = 1'b0;
        mem_rdata_i = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        n = 0;
        while (!ready_o) begin
            if (n == TIMEOUT) abort("ready_o never rose after reset");
            @(negedge clk);
            n++;
        end
        load_miss_then_hits();
        store_hit_merge();
        dirty_eviction();
        store_miss();
        random_mix();
        $display("checks done, error count %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
